/* design/dma_ingest_fsm.sv */
//************************************************************
// idle / receiving state machine for dma transfers
//************************************************************
`timescale 1ns/1ps
`default_nettype none

module dma_ingest_fsm
(
    input  wire  S_AXIS_ACLK,
    input  wire  S_AXIS_ARESETN,
    input  wire  S_AXIS_TVALID,
    input  wire  xfer_done,
    output logic receiving
);

    typedef enum logic {
        st_idle,
        st_recv
    } state_t;

    state_t state;
    state_t state_nxt;

    always_comb
    begin
        state_nxt = state;
        case (state)
            st_idle:
            begin
                if (S_AXIS_TVALID)
                    state_nxt = st_recv;  // dma is offering data
            end
            st_recv:
            begin
                if (xfer_done)
                    state_nxt = st_idle;
            end
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge S_AXIS_ACLK)
    begin
        if (!S_AXIS_ARESETN)
            state <= st_idle;
        else
            state <= state_nxt;
    end

    assign receiving = (state == st_recv);

endmodule

`default_nettype wire

/* design/dma_symbol_counter.sv */
//************************************************************
// per-transfer beat counter with limit and end detection
//************************************************************
`timescale 1ns/1ps
`default_nettype none

module dma_symbol_counter
(
    input  wire                                   S_AXIS_ACLK,
    input  wire                                   S_AXIS_ARESETN,
    input  wire                                   beat_accept,
    input  wire                                   S_AXIS_TLAST,
    input  wire  [tx_intf_pkg::max_sym_width-1:0] num_symbol,
    input  wire                                   endless,
    output wire                                   limit_hit,
    output logic                                  xfer_done
);
    import tx_intf_pkg::*;

    logic [max_sym_width-1:0] sym_count;
    logic [max_sym_width-1:0] next_count;
    logic                     last_beat;

    assign next_count = sym_count + 1'b1;

    // this beat closes the transfer
    assign last_beat = S_AXIS_TLAST || (!endless && (next_count == num_symbol));

    // also held during the done pulse so a tlast end takes no extra beat
    assign limit_hit = xfer_done || (!endless && (sym_count == num_symbol));

    always_ff @(posedge S_AXIS_ACLK)
    begin
        if (!S_AXIS_ARESETN)
        begin
            sym_count <= '0;
            xfer_done <= 1'b0;
        end
        else if (xfer_done)
        begin
            sym_count <= '0;  // ready for next transfer
            xfer_done <= 1'b0;
        end
        else if (beat_accept)
        begin
            sym_count <= next_count;
            xfer_done <= last_beat;
        end
    end

endmodule

`default_nettype wire

/* design/tx_cfg_apb.sv */
//************************************************************
// apb register block for transfer setup and fill readback
//************************************************************
`timescale 1ns/1ps
`default_nettype none

module tx_cfg_apb
(
    input  wire                                     S_AXIS_ACLK,
    input  wire                                     S_AXIS_ARESETN,
    input  wire  [tx_intf_pkg::apb_addr_width-1:0]  paddr,
    input  wire                                     psel,
    input  wire                                     penable,
    input  wire                                     pwrite,
    input  wire  [tx_intf_pkg::apb_data_width-1:0]  pwdata,
    output logic [tx_intf_pkg::apb_data_width-1:0]  prdata,
    output wire                                     pready,
    output wire                                     pslverr,
    output logic [tx_intf_pkg::max_sym_width-1:0]   num_symbol,
    output logic [tx_intf_pkg::queue_idx_width-1:0] wr_queue,
    output logic [tx_intf_pkg::queue_idx_width-1:0] rd_queue,
    output logic                                    endless,
    input  wire  [tx_intf_pkg::max_sym_width-1:0]   fill_count0,
    input  wire  [tx_intf_pkg::max_sym_width-1:0]   fill_count1,
    input  wire  [tx_intf_pkg::max_sym_width-1:0]   fill_count2,
    input  wire  [tx_intf_pkg::max_sym_width-1:0]   fill_count3
);
    import tx_intf_pkg::*;

    logic addr_hit;
    logic wr_access;

    assign pready    = 1'b1;  // no wait states
    assign pslverr   = psel && penable && !addr_hit;
    assign wr_access = psel && penable && pwrite;

    // read mux and address decode
    always_comb
    begin
        prdata   = '0;
        addr_hit = 1'b1;
        case (paddr)
            reg_num_symbol:        prdata[max_sym_width-1:0] = num_symbol;
            reg_ctrl:
            begin
                prdata[ctrl_wr_lsb +: queue_idx_width] = wr_queue;
                prdata[ctrl_rd_lsb +: queue_idx_width] = rd_queue;
                prdata[ctrl_endless_bit]               = endless;
            end
            reg_fill_base:         prdata[max_sym_width-1:0] = fill_count0;
            reg_fill_base + 8'h04: prdata[max_sym_width-1:0] = fill_count1;
            reg_fill_base + 8'h08: prdata[max_sym_width-1:0] = fill_count2;
            reg_fill_base + 8'h0c: prdata[max_sym_width-1:0] = fill_count3;
            default:               addr_hit = 1'b0;
        endcase
    end

    always_ff @(posedge S_AXIS_ACLK)
    begin
        if (!S_AXIS_ARESETN)
        begin
            num_symbol <= '0;
            wr_queue   <= '0;
            rd_queue   <= '0;
            endless    <= 1'b0;
        end
        else if (wr_access)
        begin
            case (paddr)
                reg_num_symbol: num_symbol <= pwdata[max_sym_width-1:0];
                reg_ctrl:
                begin
                    wr_queue <= pwdata[ctrl_wr_lsb +: queue_idx_width];
                    rd_queue <= pwdata[ctrl_rd_lsb +: queue_idx_width];
                    endless  <= pwdata[ctrl_endless_bit];
                end
                default: ;  // fill counts are read only
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/tx_intf_pkg.sv */
//************************************************************
// shared widths, queue count and apb register map
//************************************************************
`default_nettype none

package tx_intf_pkg;

    // stream and queue payload
    localparam int tdata_width     = 64;  // one baseband symbol per beat
    localparam int num_queues      = 4;
    localparam int queue_idx_width = 2;
    localparam int max_sym_width   = 14;  // symbol count and fill count

    // apb bus
    localparam int apb_addr_width  = 8;
    localparam int apb_data_width  = 32;

    // register offsets
    localparam logic [apb_addr_width-1:0] reg_num_symbol = 8'h00;
    localparam logic [apb_addr_width-1:0] reg_ctrl       = 8'h04;
    localparam logic [apb_addr_width-1:0] reg_fill_base  = 8'h10;  // stride of 4 per queue

    // field positions inside reg_ctrl
    localparam int ctrl_wr_lsb      = 0;  // write queue select
    localparam int ctrl_rd_lsb      = 2;  // read queue select
    localparam int ctrl_endless_bit = 4;

endpackage

`default_nettype wire

/* design/tx_intf_top.sv */
//************************************************************
// transmit intake top level
//************************************************************
`timescale 1ns/1ps
`default_nettype none

module tx_intf_top #
(
    parameter int FIFO_DEPTH_LOG2 = 12
)
(
    input  wire                                      S_AXIS_ACLK,
    input  wire                                      S_AXIS_ARESETN,
    input  wire  [tx_intf_pkg::tdata_width-1:0]      S_AXIS_TDATA,
    input  wire  [tx_intf_pkg::tdata_width/8-1:0]    S_AXIS_TSTRB,  // full beats only
    input  wire                                      S_AXIS_TLAST,
    input  wire                                      S_AXIS_TVALID,
    output wire                                      S_AXIS_TREADY,
    input  wire  [tx_intf_pkg::apb_addr_width-1:0]   paddr,
    input  wire                                      psel,
    input  wire                                      penable,
    input  wire                                      pwrite,
    input  wire  [tx_intf_pkg::apb_data_width-1:0]   pwdata,
    output wire  [tx_intf_pkg::apb_data_width-1:0]   prdata,
    output wire                                      pready,
    output wire                                      pslverr,
    output wire  [tx_intf_pkg::tdata_width-1:0]      acc_data,
    output wire                                      acc_data_valid,
    input  wire                                      acc_pop,
    output wire                                      recv_busy
);
    import tx_intf_pkg::*;

    logic [max_sym_width-1:0]   num_symbol;
    logic [queue_idx_width-1:0] wr_queue;
    logic [queue_idx_width-1:0] rd_queue;
    logic                       endless;
    logic [max_sym_width-1:0]   fill_count0;
    logic [max_sym_width-1:0]   fill_count1;
    logic [max_sym_width-1:0]   fill_count2;
    logic [max_sym_width-1:0]   fill_count3;
    logic                       receiving;
    logic                       beat_accept;
    logic                       limit_hit;
    logic                       xfer_done;

    assign recv_busy = receiving;

    tx_cfg_apb tx_cfg_apb_inst (
        .S_AXIS_ACLK    (S_AXIS_ACLK),
        .S_AXIS_ARESETN (S_AXIS_ARESETN),
        .paddr          (paddr),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .pwdata         (pwdata),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .num_symbol     (num_symbol),
        .wr_queue       (wr_queue),
        .rd_queue       (rd_queue),
        .endless        (endless),
        .fill_count0    (fill_count0),
        .fill_count1    (fill_count1),
        .fill_count2    (fill_count2),
        .fill_count3    (fill_count3)
    );

    dma_ingest_fsm dma_ingest_fsm_inst (
        .S_AXIS_ACLK    (S_AXIS_ACLK),
        .S_AXIS_ARESETN (S_AXIS_ARESETN),
        .S_AXIS_TVALID  (S_AXIS_TVALID),
        .xfer_done      (xfer_done),
        .receiving      (receiving)
    );

    dma_symbol_counter dma_symbol_counter_inst (
        .S_AXIS_ACLK    (S_AXIS_ACLK),
        .S_AXIS_ARESETN (S_AXIS_ARESETN),
        .beat_accept    (beat_accept),
        .S_AXIS_TLAST   (S_AXIS_TLAST),
        .num_symbol     (num_symbol),
        .endless        (endless),
        .limit_hit      (limit_hit),
        .xfer_done      (xfer_done)
    );

    tx_queue_bank #(
        .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    ) tx_queue_bank_inst (
        .S_AXIS_ACLK    (S_AXIS_ACLK),
        .S_AXIS_ARESETN (S_AXIS_ARESETN),
        .S_AXIS_TDATA   (S_AXIS_TDATA),
        .S_AXIS_TVALID  (S_AXIS_TVALID),
        .S_AXIS_TREADY  (S_AXIS_TREADY),
        .receiving      (receiving),
        .limit_hit      (limit_hit),
        .wr_queue       (wr_queue),
        .rd_queue       (rd_queue),
        .beat_accept    (beat_accept),
        .acc_data       (acc_data),
        .acc_data_valid (acc_data_valid),
        .acc_pop        (acc_pop),
        .fill_count0    (fill_count0),
        .fill_count1    (fill_count1),
        .fill_count2    (fill_count2),
        .fill_count3    (fill_count3)
    );

endmodule

`default_nettype wire

/* design/tx_queue_bank.sv */
//************************************************************
// four transmit queues with stream write and accelerator read
//************************************************************
`timescale 1ns/1ps
`default_nettype none

module tx_queue_bank #
(
    parameter int FIFO_DEPTH_LOG2 = 12
)
(
    input  wire                                     S_AXIS_ACLK,
    input  wire                                     S_AXIS_ARESETN,
    input  wire  [tx_intf_pkg::tdata_width-1:0]     S_AXIS_TDATA,
    input  wire                                     S_AXIS_TVALID,
    output wire                                     S_AXIS_TREADY,
    input  wire                                     receiving,
    input  wire                                     limit_hit,
    input  wire  [tx_intf_pkg::queue_idx_width-1:0] wr_queue,
    input  wire  [tx_intf_pkg::queue_idx_width-1:0] rd_queue,
    output wire                                     beat_accept,
    output wire  [tx_intf_pkg::tdata_width-1:0]     acc_data,
    output wire                                     acc_data_valid,
    input  wire                                     acc_pop,
    output wire  [tx_intf_pkg::max_sym_width-1:0]   fill_count0,
    output wire  [tx_intf_pkg::max_sym_width-1:0]   fill_count1,
    output wire  [tx_intf_pkg::max_sym_width-1:0]   fill_count2,
    output wire  [tx_intf_pkg::max_sym_width-1:0]   fill_count3
);
    import tx_intf_pkg::*;

    logic [num_queues-1:0]    q_wr_en;
    logic [num_queues-1:0]    q_rd_en;
    logic [num_queues-1:0]    q_empty;
    logic [num_queues-1:0]    q_full;
    logic [tdata_width-1:0]   q_data [num_queues];
    logic [max_sym_width-1:0] q_fill [num_queues];

    // write side follows the stream handshake
    assign S_AXIS_TREADY = receiving && !limit_hit && !q_full[wr_queue];
    assign beat_accept   = S_AXIS_TVALID && S_AXIS_TREADY;

    // read side toward the accelerator
    assign acc_data       = q_data[rd_queue];
    assign acc_data_valid = !q_empty[rd_queue];

    assign fill_count0 = q_fill[0];
    assign fill_count1 = q_fill[1];
    assign fill_count2 = q_fill[2];
    assign fill_count3 = q_fill[3];

    genvar q;
    generate
        for (q = 0; q < num_queues; q = q + 1)
        begin : g_queue
            assign q_wr_en[q] = beat_accept && (wr_queue == queue_idx_width'(q));
            assign q_rd_en[q] = acc_pop && (rd_queue == queue_idx_width'(q));  // selected only

            tx_queue_fifo #(
                .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
            ) tx_queue_fifo_inst (
                .S_AXIS_ACLK    (S_AXIS_ACLK),
                .S_AXIS_ARESETN (S_AXIS_ARESETN),
                .wr_en          (q_wr_en[q]),
                .wr_data        (S_AXIS_TDATA),
                .rd_en          (q_rd_en[q]),
                .rd_data        (q_data[q]),
                .empty          (q_empty[q]),
                .full           (q_full[q]),
                .fill_count     (q_fill[q])
            );
        end
    endgenerate

endmodule

`default_nettype wire

/* design/tx_queue_fifo.sv */
//************************************************************
// single clock fwft fifo with fill count
//************************************************************
`timescale 1ns/1ps
`default_nettype none

module tx_queue_fifo #
(
    parameter int FIFO_DEPTH_LOG2 = 12
)
(
    input  wire                                   S_AXIS_ACLK,
    input  wire                                   S_AXIS_ARESETN,
    input  wire                                   wr_en,
    input  wire  [tx_intf_pkg::tdata_width-1:0]   wr_data,
    input  wire                                   rd_en,
    output wire  [tx_intf_pkg::tdata_width-1:0]   rd_data,
    output wire                                   empty,
    output wire                                   full,
    output wire  [tx_intf_pkg::max_sym_width-1:0] fill_count
);
    import tx_intf_pkg::*;

    localparam int depth = 2 ** FIFO_DEPTH_LOG2;
    localparam logic [max_sym_width-1:0] depth_cnt = max_sym_width'(depth);

    logic [tdata_width-1:0]     mem [depth];
    logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
    logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
    logic [max_sym_width-1:0]   count;
    logic                       do_wr;
    logic                       do_rd;

    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;  // pop on empty is dropped

    assign empty      = (count == '0);
    assign full       = (count == depth_cnt);
    assign fill_count = count;
    assign rd_data    = mem[rd_ptr];  // head word always on the output

    always_ff @(posedge S_AXIS_ACLK)
    begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
    end

    always_ff @(posedge S_AXIS_ACLK)
    begin
        if (!S_AXIS_ARESETN)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;  // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tx_intf_tb -f vlog.f -o tx_intf_sim

sim_out=$(./obj_dir/tx_intf_sim 2>&1 || true)
echo "$sim_out"
if ! grep -qx "TB PASSED" <<< "$sim_out"; then
    exit 1
fi

/* tests/tx_intf_checker.sv */
//************************************************************
// stream and apb port assertions, bound into the top level
//************************************************************
`timescale 1ns/1ps
`default_nettype none

module tx_intf_checker #
(
    parameter int FIFO_DEPTH_LOG2 = 12
)
(
    input wire                                     S_AXIS_ACLK,
    input wire                                     S_AXIS_ARESETN,
    input wire                                     S_AXIS_TVALID,
    input wire                                     S_AXIS_TREADY,
    input wire                                     S_AXIS_TLAST,
    input wire  [tx_intf_pkg::apb_addr_width-1:0]  paddr,
    input wire                                     psel,
    input wire                                     penable,
    input wire                                     pslverr,
    input wire                                     acc_pop,
    input wire  [tx_intf_pkg::queue_idx_width-1:0] wr_queue,
    input wire  [tx_intf_pkg::queue_idx_width-1:0] rd_queue,
    input wire  [tx_intf_pkg::max_sym_width-1:0]   fill_count0,
    input wire  [tx_intf_pkg::max_sym_width-1:0]   fill_count1,
    input wire  [tx_intf_pkg::max_sym_width-1:0]   fill_count2,
    input wire  [tx_intf_pkg::max_sym_width-1:0]   fill_count3
);
    import tx_intf_pkg::*;

    localparam int depth = 2 ** FIFO_DEPTH_LOG2;

    logic [max_sym_width-1:0] wr_fill;
    logic                     beat;
    logic                     addr_mapped;

    assign beat = S_AXIS_TVALID && S_AXIS_TREADY;

    // two control words, then four fill counts at a stride of 4
    assign addr_mapped = (paddr == reg_num_symbol) || (paddr == reg_ctrl) ||
                         ((paddr >= reg_fill_base) &&
                          (paddr < reg_fill_base + 8'(4 * num_queues)) &&
                          (paddr[1:0] == 2'b00));

    always_comb
    begin
        case (wr_queue)
            2'd0:    wr_fill = fill_count0;
            2'd1:    wr_fill = fill_count1;
            2'd2:    wr_fill = fill_count2;
            default: wr_fill = fill_count3;
        endcase
    end

    last_ends_xfer: assert property (@(posedge S_AXIS_ACLK) disable iff (!S_AXIS_ARESETN)
        (beat && S_AXIS_TLAST) |=> !S_AXIS_TREADY)
        else $error("tready still high after a tlast beat");

    fill_to_full: assert property (@(posedge S_AXIS_ACLK) disable iff (!S_AXIS_ARESETN)
        (beat && (wr_fill == max_sym_width'(depth - 1)) && !(acc_pop && rd_queue == wr_queue))
        |=> !S_AXIS_TREADY)
        else $error("tready still high with the write queue full");

    slverr_decode: assert property (@(posedge S_AXIS_ACLK) disable iff (!S_AXIS_ARESETN)
        (psel && penable) |-> (pslverr == !addr_mapped))
        else $error("pslverr does not match the register map");

endmodule

bind tx_intf_top tx_intf_checker #(
    .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
) tx_intf_checker_inst (
    .S_AXIS_ACLK    (S_AXIS_ACLK),
    .S_AXIS_ARESETN (S_AXIS_ARESETN),
    .S_AXIS_TVALID  (S_AXIS_TVALID),
    .S_AXIS_TREADY  (S_AXIS_TREADY),
    .S_AXIS_TLAST   (S_AXIS_TLAST),
    .paddr          (paddr),
    .psel           (psel),
    .penable        (penable),
    .pslverr        (pslverr),
    .acc_pop        (acc_pop),
    .wr_queue       (wr_queue),
    .rd_queue       (rd_queue),
    .fill_count0    (fill_count0),
    .fill_count1    (fill_count1),
    .fill_count2    (fill_count2),
    .fill_count3    (fill_count3)
);

`default_nettype wire

/* tests/tx_intf_tb.sv */
//************************************************************
// table driven testbench for the transmit intake
//************************************************************
`timescale 1ns/1ps
`default_nettype none

module tx_intf_tb;
    import tx_intf_pkg::*;

    typedef struct {
        string                      name;
        logic [queue_idx_width-1:0] wr_q;
        logic [queue_idx_width-1:0] rd_q;
        int                         num_sym;
        logic                       endless;
        int                         beats;
        int                         last_pos;  // 0 for no tlast
        int                         exp_acc;
        int                         pop_at;    // stall level before early pops
        logic                       probe;     // touch unmapped offset 0x08
    } row_t;

    localparam int num_rows = 7;

    logic                      S_AXIS_ACLK    = 1'b0;
    logic                      S_AXIS_ARESETN = 1'b0;
    logic [tdata_width-1:0]    S_AXIS_TDATA   = '0;
    logic [tdata_width/8-1:0]  S_AXIS_TSTRB   = '1;
    logic                      S_AXIS_TLAST   = 1'b0;
    logic                      S_AXIS_TVALID  = 1'b0;
    wire                       S_AXIS_TREADY;
    logic [apb_addr_width-1:0] paddr          = '0;
    logic                      psel           = 1'b0;
    logic                      penable        = 1'b0;
    logic                      pwrite         = 1'b0;
    logic [apb_data_width-1:0] pwdata         = '0;
    wire  [apb_data_width-1:0] prdata;
    wire                       pready;
    wire                       pslverr;
    wire  [tdata_width-1:0]    acc_data;
    wire                       acc_data_valid;
    logic                      acc_pop        = 1'b0;
    wire                       recv_busy;

    row_t                   rows [num_rows];
    logic [tdata_width-1:0] model_q [num_queues][$];  // expected contents per queue
    integer                 seed        = 32'ha094;
    int                     acc_cnt     = 0;
    int                     err_cnt     = 0;
    int                     cycles      = 0;
    int                     cycle_limit = 100000;

    tx_intf_top #(.FIFO_DEPTH_LOG2(4)) tx_intf_top_inst (.*);

    always #4 S_AXIS_ACLK = ~S_AXIS_ACLK;

    always @(posedge S_AXIS_ACLK)
    begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit)
        begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic report_mismatch(input string name, input string what,
                                   input logic [63:0] exp_v, input logic [63:0] act_v);
        $display("CHECK FAILED %s %s expected %0h actual %0h", name, what, exp_v, act_v);
        err_cnt = err_cnt + 1;
    endtask

    task automatic report_fault(input string name, input string what);
        $display("ERROR %s: %s", name, what);
        err_cnt = err_cnt + 1;
    endtask

    task automatic apb_xfer(input logic wr, input logic [apb_addr_width-1:0] addr,
                            input logic [apb_data_width-1:0] wdata,
                            output logic [apb_data_width-1:0] rdata, output logic err);
        paddr  = addr;
        pwrite = wr;
        pwdata = wdata;
        psel   = 1'b1;  // setup phase
        @(posedge S_AXIS_ACLK);
        #1;
        penable = 1'b1;
        @(negedge S_AXIS_ACLK);
        rdata = prdata;
        err   = pslverr;
        if (!pready)
            report_fault("apb", "pready low during the access phase");
        @(posedge S_AXIS_ACLK);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic pop_word(input logic [queue_idx_width-1:0] q, input string name);
        logic [tdata_width-1:0] exp_word;
        exp_word = model_q[q].pop_front();
        if (!acc_data_valid)
            report_fault(name, "read port empty while data was expected");
        else if (acc_data != exp_word)
            report_mismatch(name, "acc_data", exp_word, acc_data);
        acc_pop = 1'b1;
        @(posedge S_AXIS_ACLK);
        #1;
        acc_pop = 1'b0;
    endtask

    task automatic offer_beats(input int t);
        logic [tdata_width-1:0] cur_data;
        logic                   started;
        logic                   took;
        started  = 1'b0;
        cur_data = {$random(seed), $random(seed)};
        while (acc_cnt < rows[t].beats)
        begin
            S_AXIS_TVALID = 1'b1;
            S_AXIS_TDATA  = cur_data;
            S_AXIS_TLAST  = (acc_cnt + 1 == rows[t].last_pos);
            @(negedge S_AXIS_ACLK);
            took = S_AXIS_TREADY;  // settled mid cycle
            @(posedge S_AXIS_ACLK);
            #1;
            if (took)
            begin
                model_q[rows[t].wr_q].push_back(cur_data);
                acc_cnt  = acc_cnt + 1;
                cur_data = {$random(seed), $random(seed)};
            end
            if (recv_busy)
                started = 1'b1;
            else if (started)
                break;  // surplus stays pending
        end
        S_AXIS_TVALID = 1'b0;
        S_AXIS_TLAST  = 1'b0;
    endtask

    initial
    begin
        logic [apb_data_width-1:0] rdata;
        logic [apb_data_width-1:0] ctrl_word;
        logic [apb_addr_width-1:0] fill_addr;
        logic                      err;
        string                     nm;
        int                        errs_before;
        int                        pass_tests;
        int                        total_beats;
        rows[0] = '{"q2_count",    2'd2, 2'd2, 6,  1'b0, 6,  0, 6,  0,  1'b0};
        rows[1] = '{"tlast_q0",    2'd0, 2'd1, 8,  1'b0, 8,  3, 3,  0,  1'b0};
        rows[2] = '{"q1_keeps_q0", 2'd1, 2'd0, 5,  1'b0, 5,  0, 5,  0,  1'b0};
        rows[3] = '{"surplus",     2'd1, 2'd1, 4,  1'b0, 7,  0, 4,  0,  1'b0};
        rows[4] = '{"endless",     2'd3, 2'd3, 3,  1'b1, 10, 9, 9,  0,  1'b0};
        rows[5] = '{"full_stall",  2'd3, 2'd3, 20, 1'b0, 20, 0, 20, 16, 1'b0};
        rows[6] = '{"reg_probe",   2'd2, 2'd0, 9,  1'b1, 0,  0, 0,  0,  1'b1};
        pass_tests  = 0;
        total_beats = 0;
        foreach (rows[t])
            total_beats = total_beats + rows[t].beats;
        cycle_limit = 40 * total_beats + 2000;
        repeat (2) @(posedge S_AXIS_ACLK);
        #1;
        S_AXIS_ARESETN = 1'b1;
        foreach (rows[t])
        begin
            nm          = rows[t].name;
            errs_before = err_cnt;
            ctrl_word   = {27'd0, rows[t].endless, rows[t].rd_q, rows[t].wr_q};
            fill_addr   = reg_fill_base + {4'd0, rows[t].wr_q, 2'd0};
            apb_xfer(1'b1, reg_num_symbol, 32'(rows[t].num_sym), rdata, err);
            apb_xfer(1'b1, reg_ctrl, ctrl_word, rdata, err);
            acc_cnt = 0;
            fork
                if (rows[t].beats > 0)
                    offer_beats(t);
                if (rows[t].pop_at > 0)
                begin
                    wait (acc_cnt == rows[t].pop_at);
                    repeat (4) @(posedge S_AXIS_ACLK);
                    #1;
                    if (acc_cnt != rows[t].pop_at || S_AXIS_TREADY)
                        report_fault(nm, "stream kept accepting into a full queue");
                    apb_xfer(1'b0, fill_addr, '0, rdata, err);
                    if (rdata != 32'(rows[t].pop_at))
                        report_mismatch(nm, "fill at stall", 64'(rows[t].pop_at), 64'(rdata));
                    repeat (4) pop_word(rows[t].rd_q, nm);  // frees room, stream resumes
                end
            join
            while (recv_busy)
            begin
                @(posedge S_AXIS_ACLK);
                #1;
            end
            if (acc_cnt != rows[t].exp_acc)
                report_mismatch(nm, "accepted beats", 64'(rows[t].exp_acc), 64'(acc_cnt));
            apb_xfer(1'b0, reg_num_symbol, '0, rdata, err);
            if (rdata != 32'(rows[t].num_sym))
                report_mismatch(nm, "num_symbol reg", 64'(rows[t].num_sym), 64'(rdata));
            apb_xfer(1'b0, reg_ctrl, '0, rdata, err);
            if (rdata != ctrl_word)
                report_mismatch(nm, "ctrl reg", 64'(ctrl_word), 64'(rdata));
            apb_xfer(1'b0, fill_addr, '0, rdata, err);
            if (rdata != 32'(model_q[rows[t].wr_q].size()))
                report_mismatch(nm, "fill count", 64'(model_q[rows[t].wr_q].size()), 64'(rdata));
            if (err)
                report_fault(nm, "pslverr raised on a fill count read");
            if (rows[t].probe)
            begin
                apb_xfer(1'b0, 8'h08, '0, rdata, err);
                if (!err)
                    report_fault(nm, "no pslverr on unmapped offset 0x08");
            end
            while (model_q[rows[t].rd_q].size() > 0)
                pop_word(rows[t].rd_q, nm);
            if (acc_data_valid)
                report_fault(nm, "read port still valid after the queue was drained");
            if (err_cnt == errs_before)
            begin
                pass_tests = pass_tests + 1;
                $display("test %s ok", nm);
            end
            else
                $display("test %s failed with %0d errors", nm, err_cnt - errs_before);
        end
        $display("%0d tests passed, %0d tests failed", pass_tests, num_rows - pass_tests);
        if (err_cnt == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
design/tx_intf_pkg.sv
design/tx_cfg_apb.sv
design/dma_ingest_fsm.sv
design/dma_symbol_counter.sv
design/tx_queue_fifo.sv
design/tx_queue_bank.sv
design/tx_intf_top.sv
tests/tx_intf_checker.sv
tests/tx_intf_tb.sv
